//--- Bender.yml
package:
  name: spi_multi_master

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/spi_pkg.sv
      - hdl/spi_cmd_dispatch.sv
      - hdl/spi_channel.sv
      - hdl/spi_rsp_arbiter.sv
      - hdl/spi_multi_master.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - tests/spi_clk_gen.sv
      - tests/spi_multi_master_checker.sv
      - tests/spi_multi_master_tb.sv

//--- hdl/spi_channel.sv
`timescale 1ns/1ps
`include "spi_params.svh"

module spi_channel import spi_pkg::*; (
    input  logic                    clk,
    input  logic                    rst,
    input  spi_cmd_t                cmd,
    input  logic                    cmd_valid,
    output logic                    cmd_ready,
    output spi_rsp_t                rsp,
    output logic                    rsp_valid,
    input  logic                    rsp_ready,
    input  logic [`SPI_CHAN_W-1:0]  chan_id,
    output logic                    sclk,
    output logic                    mosi,
    output logic                    en,
    input  logic                    miso
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ACTIVE,
        ST_DONE
    } state_t;

    state_t                  state;
    logic [`SPI_HALF_W-1:0]  half_reg;
    logic [`SPI_HALF_W-1:0]  half_cnt;
    logic [2:0]              bit_cnt;
    logic [7:0]              tx_sr;
    logic [7:0]              rx_sr;
    logic [7:0]              rsp_byte;
    logic                    cmd_fire;
    logic                    xfer_start;
    logic                    cfg_load;
    logic                    half_end;

    // Accept only when idle with an empty response slot
    assign cmd_ready  = (state == ST_IDLE) && !rsp_valid;
    assign cmd_fire   = cmd_valid && cmd_ready;
    assign xfer_start = cmd_fire && (cmd.op == OP_XFER);
    assign cfg_load   = cmd_fire && (cmd.op == OP_CFG);

    // Last clk cycle of an sclk half-period
    assign half_end = (half_cnt == half_reg - 1'b1);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            half_reg <= `SPI_HALF_W'(`SPI_HALF_DEFAULT);
        end else if (cfg_load) begin
            if (cmd.payload.cfg.half == '0) begin
                half_reg <= `SPI_HALF_W'(1);
            end else begin
                half_reg <= cmd.payload.cfg.half;
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= ST_IDLE;
            sclk     <= 1'b1;
            half_cnt <= '0;
            bit_cnt  <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    half_cnt <= '0;
                    bit_cnt  <= '0;
                    if (xfer_start) begin
                        state <= ST_ACTIVE;
                    end
                end
                ST_ACTIVE: begin
                    if (half_end) begin
                        half_cnt <= '0;
                        sclk     <= !sclk;
                        // Rising edge closes a bit
                        if (!sclk) begin
                            bit_cnt <= bit_cnt + 1'b1;
                            if (bit_cnt == 3'd7) begin
                                state <= ST_DONE;
                            end
                        end
                    end else begin
                        half_cnt <= half_cnt + 1'b1;
                    end
                end
                ST_DONE: begin
                    state <= ST_IDLE;
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // Shift registers, MISO in on falling sclk, MOSI moves on rising sclk
    always_ff @(posedge clk) begin
        if (xfer_start) begin
            tx_sr <= cmd.payload.tx_byte;
        end else if (state == ST_ACTIVE && half_end) begin
            if (sclk) begin
                rx_sr <= {rx_sr[6:0], miso};
            end else begin
                tx_sr <= {tx_sr[6:0], 1'b0};
            end
        end
    end

    // Response slot
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rsp_valid <= 1'b0;
        end else if (state == ST_DONE) begin
            rsp_valid <= 1'b1;
        end else if (rsp_valid && rsp_ready) begin
            rsp_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (state == ST_DONE) begin
            rsp_byte <= rx_sr;
        end
    end

    assign rsp.chan    = chan_id;
    assign rsp.rx_byte = rsp_byte;

    assign en   = (state == ST_ACTIVE);
    assign mosi = en ? tx_sr[7] : 1'b0;

endmodule

//--- hdl/spi_cmd_dispatch.sv
`timescale 1ns/1ps
`include "spi_params.svh"

module spi_cmd_dispatch import spi_pkg::*; (
    input  spi_cmd_t                  cmd,
    input  logic                      cmd_valid,
    output logic                      cmd_ready,
    output spi_cmd_t                  ch_cmd,
    output logic [`SPI_NUM_CHAN-1:0]  ch_cmd_valid,
    input  logic [`SPI_NUM_CHAN-1:0]  ch_cmd_ready
);

    // All channels see the same command word
    assign ch_cmd = cmd;

    // One-hot valid towards the addressed channel
    always_comb begin
        ch_cmd_valid = '0;
        ch_cmd_valid[cmd.chan] = cmd_valid;
    end

    // Ready comes back from the addressed channel only
    assign cmd_ready = ch_cmd_ready[cmd.chan];

endmodule

//--- hdl/spi_multi_master.sv
`timescale 1ns/1ps
`include "spi_params.svh"

module spi_multi_master import spi_pkg::*; (
    input  logic                      clk,
    input  logic                      rst,
    input  spi_cmd_t                  cmd,
    input  logic                      cmd_valid,
    output logic                      cmd_ready,
    output spi_rsp_t                  rsp,
    output logic                      rsp_valid,
    input  logic                      rsp_ready,
    output logic [`SPI_NUM_CHAN-1:0]  sclk,
    output logic [`SPI_NUM_CHAN-1:0]  mosi,
    output logic [`SPI_NUM_CHAN-1:0]  en,
    input  logic [`SPI_NUM_CHAN-1:0]  miso
);

    spi_cmd_t                  ch_cmd;
    logic [`SPI_NUM_CHAN-1:0]  ch_cmd_valid;
    logic [`SPI_NUM_CHAN-1:0]  ch_cmd_ready;
    spi_rsp_t                  ch_rsp [`SPI_NUM_CHAN];
    logic [`SPI_NUM_CHAN-1:0]  ch_rsp_valid;
    logic [`SPI_NUM_CHAN-1:0]  ch_rsp_ready;

    spi_cmd_dispatch dispatch_i (
        .cmd          (cmd),
        .cmd_valid    (cmd_valid),
        .cmd_ready    (cmd_ready),
        .ch_cmd       (ch_cmd),
        .ch_cmd_valid (ch_cmd_valid),
        .ch_cmd_ready (ch_cmd_ready)
    );

    // One engine per channel, tagged with its index
    for (genvar i = 0; i < `SPI_NUM_CHAN; i++) begin : g_chan
        spi_channel channel_i (
            .clk       (clk),
            .rst       (rst),
            .cmd       (ch_cmd),
            .cmd_valid (ch_cmd_valid[i]),
            .cmd_ready (ch_cmd_ready[i]),
            .rsp       (ch_rsp[i]),
            .rsp_valid (ch_rsp_valid[i]),
            .rsp_ready (ch_rsp_ready[i]),
            .chan_id   (`SPI_CHAN_W'(i)),
            .sclk      (sclk[i]),
            .mosi      (mosi[i]),
            .en        (en[i]),
            .miso      (miso[i])
        );
    end

    spi_rsp_arbiter arbiter_i (
        .clk          (clk),
        .rst          (rst),
        .ch_rsp       (ch_rsp),
        .ch_rsp_valid (ch_rsp_valid),
        .ch_rsp_ready (ch_rsp_ready),
        .rsp          (rsp),
        .rsp_valid    (rsp_valid),
        .rsp_ready    (rsp_ready)
    );

endmodule

//--- hdl/spi_params.svh
`ifndef SPI_PARAMS_SVH
`define SPI_PARAMS_SVH

// Number of SPI channel engines
`define SPI_NUM_CHAN 4

// Channel number width, covers SPI_NUM_CHAN exactly
`define SPI_CHAN_W 2

// Half-period setting width, in clk cycles
`define SPI_HALF_W 4

// Half-period after reset
`define SPI_HALF_DEFAULT 2

`endif

//--- hdl/spi_pkg.sv
`include "spi_params.svh"

package spi_pkg;

    typedef enum logic {
        OP_XFER = 1'b0,
        OP_CFG  = 1'b1
    } spi_op_t;

    // Config view, half-period of zero acts as one
    typedef struct packed {
        logic [7-`SPI_HALF_W:0]  rsvd;
        logic [`SPI_HALF_W-1:0]  half;
    } spi_cfg_t;

    // Same byte, meaning set by op
    typedef union packed {
        logic [7:0] tx_byte;
        spi_cfg_t   cfg;
    } spi_payload_u;

    typedef struct packed {
        spi_op_t                 op;
        logic [`SPI_CHAN_W-1:0]  chan;
        spi_payload_u            payload;
    } spi_cmd_t;

    typedef struct packed {
        logic [`SPI_CHAN_W-1:0]  chan;
        logic [7:0]              rx_byte;
    } spi_rsp_t;

endpackage

//--- hdl/spi_rsp_arbiter.sv
`timescale 1ns/1ps
`include "spi_params.svh"

module spi_rsp_arbiter import spi_pkg::*; (
    input  logic                      clk,
    input  logic                      rst,
    input  spi_rsp_t                  ch_rsp [`SPI_NUM_CHAN],
    input  logic [`SPI_NUM_CHAN-1:0]  ch_rsp_valid,
    output logic [`SPI_NUM_CHAN-1:0]  ch_rsp_ready,
    output spi_rsp_t                  rsp,
    output logic                      rsp_valid,
    input  logic                      rsp_ready
);

    logic [`SPI_CHAN_W-1:0]  ptr;
    logic [`SPI_CHAN_W-1:0]  pick;
    logic [`SPI_CHAN_W-1:0]  sel;
    logic [`SPI_CHAN_W-1:0]  held_idx;
    logic                    hold;

    // First valid channel at or after the priority pointer
    always_comb begin
        logic                    found;
        logic [`SPI_CHAN_W-1:0]  idx;
        found = 1'b0;
        pick  = ptr;
        for (int k = 0; k < `SPI_NUM_CHAN; k++) begin
            idx = ptr + `SPI_CHAN_W'(k);
            if (!found && ch_rsp_valid[idx]) begin
                found = 1'b1;
                pick  = idx;
            end
        end
    end

    // Grant frozen while the output waits for ready
    assign sel       = hold ? held_idx : pick;
    assign rsp       = ch_rsp[sel];
    assign rsp_valid = ch_rsp_valid[sel];

    always_comb begin
        ch_rsp_ready = '0;
        ch_rsp_ready[sel] = rsp_ready;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ptr      <= '0;
            hold     <= 1'b0;
            held_idx <= '0;
        end else if (rsp_valid && rsp_ready) begin
            ptr  <= sel + 1'b1;
            hold <= 1'b0;
        end else if (rsp_valid) begin
            hold     <= 1'b1;
            held_idx <= sel;
        end
    end

endmodule

//--- spi_multi_master.f
+incdir+hdl
hdl/spi_pkg.sv
hdl/spi_cmd_dispatch.sv
hdl/spi_channel.sv
hdl/spi_rsp_arbiter.sv
hdl/spi_multi_master.sv
tests/spi_clk_gen.sv
tests/spi_multi_master_checker.sv
tests/spi_multi_master_tb.sv

//--- tests/spi_clk_gen.sv
`timescale 1ns/1ps

module spi_clk_gen #(
    parameter real PERIOD = 100.0
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2.0) clk = ~clk;
    end

endmodule

//--- tests/spi_multi_master_checker.sv
`timescale 1ns/1ps
`include "spi_params.svh"

module spi_multi_master_checker import spi_pkg::*; (
    input logic                      clk,
    input logic                      rst,
    input spi_cmd_t                  cmd,
    input logic                      cmd_valid,
    input logic                      cmd_ready,
    input spi_rsp_t                  rsp,
    input logic                      rsp_valid,
    input logic                      rsp_ready,
    input logic [`SPI_NUM_CHAN-1:0]  sclk,
    input logic [`SPI_NUM_CHAN-1:0]  mosi,
    input logic [`SPI_NUM_CHAN-1:0]  en
);

    // Count of failed assertions
    int viol_cnt = 0;

    // Payload and valid held until the handshake
    a_cmd_stable: assert property (@(posedge clk) disable iff (rst)
        cmd_valid && !cmd_ready |=> cmd_valid && $stable(cmd))
        else begin
            $error("cmd changed or cmd_valid dropped before handshake");
            viol_cnt++;
        end

    a_rsp_stable: assert property (@(posedge clk) disable iff (rst)
        rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp))
        else begin
            $error("rsp changed or rsp_valid dropped before handshake");
            viol_cnt++;
        end

    // Idle SPI pads with CPOL 1
    for (genvar i = 0; i < `SPI_NUM_CHAN; i++) begin : g_idle
        a_idle_pads: assert property (@(posedge clk)
            !en[i] |-> sclk[i] && !mosi[i])
            else begin
                $error("channel %0d sclk or mosi not idle while en is low", i);
                viol_cnt++;
            end
    end

    a_rsp_reset: assert property (@(posedge clk) rst |-> !rsp_valid)
        else begin
            $error("rsp_valid high during reset");
            viol_cnt++;
        end

endmodule

bind spi_multi_master spi_multi_master_checker checker_i (.*);

//--- tests/spi_multi_master_tb.sv
`timescale 1ns/1ps
`include "spi_params.svh"

module spi_multi_master_tb import spi_pkg::*; ();

    localparam int RESET_CYC   = 16;
    localparam int N_SINGLE    = `SPI_NUM_CHAN;
    localparam int N_CFG       = 3;
    localparam int N_RAND      = 40;
    localparam int MAX_HALF    = 7;
    localparam int N_FRAMES    = N_SINGLE + N_CFG + 2 * N_RAND;
    localparam int FRAME_CYC   = N_FRAMES * 16 * MAX_HALF;
    localparam int TIMEOUT_CYC = FRAME_CYC + 2 * FRAME_CYC + RESET_CYC;

    logic                      clk;
    logic                      rst;
    spi_cmd_t                  cmd;
    logic                      cmd_valid;
    logic                      cmd_ready;
    spi_rsp_t                  rsp;
    logic                      rsp_valid;
    logic                      rsp_ready;
    logic [`SPI_NUM_CHAN-1:0]  sclk;
    logic [`SPI_NUM_CHAN-1:0]  mosi;
    logic [`SPI_NUM_CHAN-1:0]  en;
    logic [`SPI_NUM_CHAN-1:0]  miso;

    spi_rsp_t                  exp_q [`SPI_NUM_CHAN][$];
    int                        half_exp [`SPI_NUM_CHAN] = '{default: `SPI_HALF_DEFAULT};
    int                        hcnt [`SPI_NUM_CHAN] = '{default: 0};
    logic [`SPI_NUM_CHAN-1:0]  prev_en = '0;
    logic [`SPI_NUM_CHAN-1:0]  prev_sclk = '1;
    logic [7:0]                single_bytes [N_SINGLE] = '{8'h00, 8'hff, 8'ha5, 8'h3c};
    integer                    seed = 32'h334d;
    integer                    ready_seed;
    int                        err_cnt = 0;
    int                        err_base = 0;
    int                        pass_cnt = 0;
    int                        fail_cnt = 0;
    int                        rsp_cnt = 0;
    int                        edges_seen = 0;
    int                        cycle_cnt = 0;
    logic                      bp_done = 1'b0;

    spi_clk_gen #(.PERIOD(100.0)) clk_gen_i (.clk(clk));

    spi_multi_master dut_i (.*);

    // Slave stand-in that returns each MOSI inverted on MISO
    assign miso = ~mosi;

    // Loopback through an inverter returns the complement of the byte sent
    function automatic spi_rsp_t ref_rsp(input logic [7:0] tx,
                                         input logic [`SPI_CHAN_W-1:0] ch);
        spi_rsp_t r;
        r.chan    = ch;
        r.rx_byte = ~tx;
        return r;
    endfunction

    function automatic spi_cmd_t make_xfer(input logic [`SPI_CHAN_W-1:0] ch,
                                           input logic [7:0] b);
        spi_cmd_t c;
        c.op              = OP_XFER;
        c.chan            = ch;
        c.payload.tx_byte = b;
        return c;
    endfunction

    function automatic spi_cmd_t make_cfg(input logic [`SPI_CHAN_W-1:0] ch, input int h);
        spi_cmd_t c;
        c.op               = OP_CFG;
        c.chan             = ch;
        c.payload.cfg.rsvd = '0;
        c.payload.cfg.half = h[`SPI_HALF_W-1:0];
        return c;
    endfunction

    function automatic int pending();
        int n = 0;
        for (int c = 0; c < `SPI_NUM_CHAN; c++) begin
            n += exp_q[c].size();
        end
        return n;
    endfunction

    task automatic check_equal(input string name, input logic [31:0] expv,
                               input logic [31:0] act);
        assert (expv === act) else begin
            $display("mismatch %s expected %h actual %h", name, expv, act);
            err_cnt++;
        end
    endtask

    task automatic check_idle();
        check_equal("rsp_valid", 0, rsp_valid);
        check_equal("en", 0, en);
        check_equal("sclk", {`SPI_NUM_CHAN{1'b1}}, sclk);
        check_equal("mosi", 0, mosi);
    endtask

    task automatic send_cmd(input spi_cmd_t c);
        @(negedge clk);
        cmd       = c;
        cmd_valid = 1'b1;
        // Ready depends on the addressed channel
        #1;
        while (!cmd_ready) begin
            @(negedge clk);
            #1;
        end
        @(posedge clk);
        if (c.op == OP_XFER) begin
            exp_q[c.chan].push_back(ref_rsp(c.payload.tx_byte, c.chan));
        end else begin
            half_exp[c.chan] = (c.payload.cfg.half == 0) ? 1 : c.payload.cfg.half;
        end
        @(negedge clk);
        cmd_valid = 1'b0;
    endtask

    task automatic send_random_xfer();
        logic [31:0] r;
        r = $random(seed);
        send_cmd(make_xfer(r[8 +: `SPI_CHAN_W], r[7:0]));
    endtask

    task automatic wait_drain();
        while (pending() != 0) begin
            @(negedge clk);
        end
    endtask

    task automatic toggle_ready();
        logic [31:0] r;
        while (!bp_done) begin
            @(negedge clk);
            r = $random(ready_seed);
            if (r[4:0] == 5'd0) begin
                // Long stall so slots fill and channels stop accepting
                rsp_ready = 1'b0;
                repeat (40) @(negedge clk);
            end else begin
                rsp_ready = r[0];
            end
        end
        rsp_ready = 1'b1;
    endtask

    task automatic end_test(input string name);
        int errs;
        errs = err_cnt + dut_i.checker_i.viol_cnt;
        if (errs == err_base) begin
            pass_cnt++;
            $display("test %s: passed", name);
        end else begin
            fail_cnt++;
            $display("test %s: failed with %0d errors", name, errs - err_base);
        end
        err_base = errs;
    endtask

    // Response checker keeping per-channel order
    always @(posedge clk) begin : compare_rsp
        spi_rsp_t expr;
        if (!rst && rsp_valid && rsp_ready) begin
            rsp_cnt++;
            assert (exp_q[rsp.chan].size() != 0) else begin
                $display("response on channel %0d arrived with no transfer pending", rsp.chan);
                err_cnt++;
            end
            if (exp_q[rsp.chan].size() != 0) begin
                expr = exp_q[rsp.chan].pop_front();
                check_equal("rsp.rx_byte", expr.rx_byte, rsp.rx_byte);
            end
        end
    end

    // Measure sclk half-periods in clk cycles from en rising
    always @(negedge clk) begin
        for (int c = 0; c < `SPI_NUM_CHAN; c++) begin
            if (en[c] && prev_en[c]) begin
                hcnt[c]++;
                if (sclk[c] != prev_sclk[c]) begin
                    check_equal($sformatf("sclk[%0d] half-period", c), half_exp[c], hcnt[c]);
                    edges_seen++;
                    hcnt[c] = 0;
                end
            end else if (!en[c] && prev_en[c]) begin
                // Last rising edge coincides with en dropping
                check_equal($sformatf("sclk[%0d] half-period", c), half_exp[c], hcnt[c] + 1);
                check_equal($sformatf("sclk[%0d]", c), 1, sclk[c]);
                edges_seen++;
            end else begin
                hcnt[c] = 0;
            end
        end
        prev_en   = en;
        prev_sclk = sclk;
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt >= TIMEOUT_CYC) begin
            $display("timeout after %0d cycles with %0d transfers pending", cycle_cnt, pending());
            $display("sim failed");
            $finish;
        end
    end

    initial begin
        int edge_base;
        int rsp_base;
        rst        = 1'b0;
        cmd        = '0;
        cmd_valid  = 1'b0;
        rsp_ready  = 1'b0;
        ready_seed = seed + 1;
        // Rising edge at 1 ns so the asynchronous reset is seen
        #1;
        rst = 1'b1;

        repeat (RESET_CYC) begin
            @(negedge clk);
            check_idle();
        end
        rst       = 1'b0;
        rsp_ready = 1'b1;
        repeat (4) begin
            @(negedge clk);
            check_idle();
        end
        check_equal("cmd_ready", 1, cmd_ready);
        end_test("reset_state");

        for (int c = 0; c < N_SINGLE; c++) begin
            send_cmd(make_xfer(c[`SPI_CHAN_W-1:0], single_bytes[c]));
            wait_drain();
        end
        end_test("single_transfers");

        edge_base = edges_seen;
        rsp_base  = rsp_cnt;
        send_cmd(make_cfg(0, 1));
        send_cmd(make_cfg(1, 3));
        send_cmd(make_cfg(2, MAX_HALF));
        for (int c = 0; c < N_CFG; c++) begin
            send_cmd(make_xfer(c[`SPI_CHAN_W-1:0], 8'($random(seed))));
        end
        wait_drain();
        assert (edges_seen - edge_base == N_CFG * 16) else begin
            $display("expected %0d sclk edges in configured frames but saw %0d",
                     N_CFG * 16, edges_seen - edge_base);
            err_cnt++;
        end
        assert (rsp_cnt - rsp_base == N_CFG) else begin
            $display("configuration commands changed the response count");
            err_cnt++;
        end
        end_test("configuration");

        rsp_ready = 1'b1;
        repeat (N_RAND) send_random_xfer();
        wait_drain();
        end_test("concurrency");

        fork
            begin
                repeat (N_RAND) send_random_xfer();
                wait_drain();
                bp_done = 1'b1;
            end
            toggle_ready();
        join
        end_test("back_pressure");

        $display("tests passed %0d failed %0d, errors %0d", pass_cnt, fail_cnt,
                 err_cnt + dut_i.checker_i.viol_cnt);
        if (fail_cnt == 0 && err_cnt + dut_i.checker_i.viol_cnt == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule
